// File: source/lsu_pkg.sv
package lsu_pkg;

    // datapath widths
    localparam int XLEN   = 64;
    localparam int STRB_W = XLEN / 8;
    localparam int ILEN   = 32;

    // major opcodes, compared against instr[6:2]
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    // access size from funct3[1:0]
    localparam logic [1:0] F3_B = 2'd0;
    localparam logic [1:0] F3_H = 2'd1;
    localparam logic [1:0] F3_W = 2'd2;
    localparam logic [1:0] F3_D = 2'd3;

    // funct3 bit that selects zero extension on loads
    localparam int F3_UNSIGNED_BIT = 2;

    // AXI response codes, anything but OKAY counts as an error
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // response wait limit in cycles
    localparam int BUS_TIMEOUT = 64;
    localparam int TIMER_W     = 7;

endpackage

// File: source/ls_decode.sv
`timescale 1ns/100ps

module ls_decode import lsu_pkg::*; (
    input  logic [ILEN-1:0] instr_i,
    input  logic [2:0]      addr_lsb_i,
    output logic            is_load_o,
    output logic            is_store_o,
    output logic [1:0]      size_o,
    output logic            is_unsigned_o,
    output logic            misaligned_o
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       align_fault;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];

    assign is_load_o     = (opcode == OPC_LOAD);
    assign is_store_o    = (opcode == OPC_STORE);
    assign size_o        = funct3[1:0];
    assign is_unsigned_o = funct3[F3_UNSIGNED_BIT];

    // any address bit below the access size must be zero
    always_comb begin
        case (size_o)
            F3_B: begin
                align_fault = 1'b0;
            end
            F3_H: begin
                align_fault = addr_lsb_i[0];
            end
            F3_W: begin
                align_fault = |addr_lsb_i[1:0];
            end
            default: begin
                align_fault = |addr_lsb_i;
            end
        endcase
    end

    // only memory ops can fault
    assign misaligned_o = (is_load_o | is_store_o) & align_fault;

endmodule

// File: source/store_align.sv
`timescale 1ns/100ps

module store_align import lsu_pkg::*; (
    input  logic [XLEN-1:0]   rs2_i,
    input  logic [2:0]        addr_lsb_i,
    input  logic [1:0]        size_i,
    output logic [XLEN-1:0]   wdata_o,
    output logic [STRB_W-1:0] wstrb_o
);

    // strobe pattern before it is moved to the addressed lane
    logic [STRB_W-1:0] strb_base;

    // copy the operand into every lane of its size,
    // the strobe then picks the lane the slave keeps
    always_comb begin
        case (size_i)
            F3_B: begin
                wdata_o   = {(XLEN / 8){rs2_i[7:0]}};
                strb_base = 8'b0000_0001;
            end
            F3_H: begin
                wdata_o   = {(XLEN / 16){rs2_i[15:0]}};
                strb_base = 8'b0000_0011;
            end
            F3_W: begin
                wdata_o   = {(XLEN / 32){rs2_i[31:0]}};
                strb_base = 8'b0000_1111;
            end
            default: begin
                wdata_o   = rs2_i;
                strb_base = 8'b1111_1111;
            end
        endcase
    end

    // double-word accesses are aligned, so the shift is zero for them
    assign wstrb_o = strb_base << addr_lsb_i;

endmodule

// File: source/load_align.sv
`timescale 1ns/100ps

module load_align import lsu_pkg::*; (
    input  logic [XLEN-1:0] rdata_i,
    input  logic [2:0]      addr_lsb_i,
    input  logic [1:0]      size_i,
    input  logic            is_unsigned_i,
    output logic [XLEN-1:0] load_data_o
);

    logic [XLEN-1:0] shifted;
    logic            sign_b;
    logic            sign_h;
    logic            sign_w;

    // bring the addressed lane down to bit 0
    assign shifted = rdata_i >> {addr_lsb_i, 3'b000};

    // fill bit for each size, zero for the unsigned forms
    assign sign_b = ~is_unsigned_i & shifted[7];
    assign sign_h = ~is_unsigned_i & shifted[15];
    assign sign_w = ~is_unsigned_i & shifted[31];

    always_comb begin
        case (size_i)
            F3_B: begin
                load_data_o = {{(XLEN - 8){sign_b}}, shifted[7:0]};
            end
            F3_H: begin
                load_data_o = {{(XLEN - 16){sign_h}}, shifted[15:0]};
            end
            F3_W: begin
                load_data_o = {{(XLEN - 32){sign_w}}, shifted[31:0]};
            end
            default: begin
                // ld, nothing to extend
                load_data_o = rdata_i;
            end
        endcase
    end

endmodule

// File: source/bus_timer.sv
`timescale 1ns/100ps

module bus_timer import lsu_pkg::*; (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    input  logic clear_i,
    output logic expired_o
);

    logic [TIMER_W-1:0] count_q;
    logic               armed_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q   <= '0;
            armed_q   <= 1'b0;
            expired_o <= 1'b0;
        end else if (start_i) begin
            count_q   <= '0;
            armed_q   <= 1'b1;
            expired_o <= 1'b0;
        end else if (clear_i) begin
            armed_q   <= 1'b0;
            expired_o <= 1'b0;
        end else if (armed_q) begin
            count_q <= count_q + 1'b1;
            // last counted cycle, flag sticks until cleared
            if (count_q == TIMER_W'(BUS_TIMEOUT - 1)) begin
                armed_q   <= 1'b0;
                expired_o <= 1'b1;
            end
        end
    end

endmodule

// File: source/axil_ls_fsm.sv
`timescale 1ns/100ps

module axil_ls_fsm import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    // request from execute
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic [XLEN-1:0]   addr_i,
    input  logic              is_load_i,
    input  logic              is_store_i,
    input  logic              misaligned_i,
    input  logic [1:0]        size_i,
    input  logic              is_unsigned_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic [STRB_W-1:0] wstrb_i,
    // response timer
    output logic              timer_start_o,
    output logic              timer_clear_o,
    input  logic              timer_expired_i,
    // AXI4-Lite master
    output logic              m_awvalid_o,
    input  logic              m_awready_i,
    output logic [XLEN-1:0]   m_awaddr_o,
    output logic              m_wvalid_o,
    input  logic              m_wready_i,
    output logic [XLEN-1:0]   m_wdata_o,
    output logic [STRB_W-1:0] m_wstrb_o,
    input  logic              m_bvalid_i,
    output logic              m_bready_o,
    input  logic [1:0]        m_bresp_i,
    output logic              m_arvalid_o,
    input  logic              m_arready_i,
    output logic [XLEN-1:0]   m_araddr_o,
    input  logic              m_rvalid_i,
    output logic              m_rready_o,
    input  logic [XLEN-1:0]   m_rdata_i,
    input  logic [1:0]        m_rresp_i,
    // result side
    output logic [XLEN-1:0]   rdata_o,
    output logic [2:0]        rsp_lsb_o,
    output logic [1:0]        rsp_size_o,
    output logic              rsp_unsigned_o,
    output logic              load_sel_o,
    output logic              rsp_valid_o,
    output logic              rsp_err_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPLETE,
        S_WADDR,
        S_WRESP,
        S_RADDR,
        S_RDATA,
        S_DRAIN
    } state_t;

    state_t            state_q;
    logic              awvalid_q;
    logic              wvalid_q;
    logic              arvalid_q;
    logic              tmo_rsp_q;
    logic              err_q;
    logic              load_sel_q;
    logic              is_store_q;
    logic [XLEN-1:0]   addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic [XLEN-1:0]   rdata_q;
    logic [1:0]        size_q;
    logic              unsigned_q;

    logic req_fire;
    logic mem_go;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic b_hs;
    logic r_hs;
    logic aw_pend;
    logic w_pend;

    assign req_ready_o = (state_q == S_IDLE);
    assign req_fire    = req_valid_i & req_ready_o;
    assign mem_go      = (is_load_i | is_store_i) & ~misaligned_i;

    assign aw_hs   = awvalid_q & m_awready_i;
    assign w_hs    = wvalid_q & m_wready_i;
    assign ar_hs   = arvalid_q & m_arready_i;
    assign b_hs    = m_bvalid_i & m_bready_o;
    assign r_hs    = m_rvalid_i & m_rready_o;
    // still outstanding after this cycle
    assign aw_pend = awvalid_q & ~m_awready_i;
    assign w_pend  = wvalid_q & ~m_wready_i;

    // double-word base address on both channels
    assign m_awaddr_o  = {addr_q[XLEN-1:3], 3'b000};
    assign m_araddr_o  = {addr_q[XLEN-1:3], 3'b000};
    assign m_awvalid_o = awvalid_q;
    assign m_wvalid_o  = wvalid_q;
    assign m_arvalid_o = arvalid_q;
    assign m_wdata_o   = wdata_q;
    assign m_wstrb_o   = wstrb_q;

    // in drain only the channel of the hung transaction is accepted
    assign m_bready_o = (state_q == S_WRESP) | ((state_q == S_DRAIN) & is_store_q);
    assign m_rready_o = (state_q == S_RDATA) | ((state_q == S_DRAIN) & ~is_store_q);

    assign timer_start_o = req_fire & mem_go;
    assign timer_clear_o = (state_q == S_COMPLETE) | (state_q == S_DRAIN);

    // normal results leave through COMPLETE, a timeout answers from drain entry
    assign rsp_valid_o    = (state_q == S_COMPLETE) | tmo_rsp_q;
    assign rsp_err_o      = err_q;
    assign load_sel_o     = load_sel_q;
    assign rdata_o        = load_sel_q ? rdata_q : '0;
    assign rsp_lsb_o      = addr_q[2:0];
    assign rsp_size_o     = size_q;
    assign rsp_unsigned_o = unsigned_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= S_IDLE;
            awvalid_q  <= 1'b0;
            wvalid_q   <= 1'b0;
            arvalid_q  <= 1'b0;
            tmo_rsp_q  <= 1'b0;
            err_q      <= 1'b0;
            load_sel_q <= 1'b0;
        end else begin
            tmo_rsp_q <= 1'b0;
            // valids drop at their own handshake in any state
            if (aw_hs) begin
                awvalid_q <= 1'b0;
            end
            if (w_hs) begin
                wvalid_q <= 1'b0;
            end
            if (ar_hs) begin
                arvalid_q <= 1'b0;
            end

            case (state_q)
                S_IDLE: begin
                    if (req_fire) begin
                        err_q      <= misaligned_i;
                        load_sel_q <= 1'b0;
                        if (mem_go && is_store_i) begin
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                            state_q   <= S_WADDR;
                        end else if (mem_go) begin
                            arvalid_q <= 1'b1;
                            state_q   <= S_RADDR;
                        end else begin
                            state_q <= S_COMPLETE;
                        end
                    end
                end
                S_WADDR: begin
                    if (timer_expired_i) begin
                        tmo_rsp_q <= 1'b1;
                        err_q     <= 1'b1;
                        state_q   <= S_DRAIN;
                    end else if (!aw_pend && !w_pend) begin
                        state_q <= S_WRESP;
                    end
                end
                S_WRESP: begin
                    if (b_hs) begin
                        err_q   <= (m_bresp_i != RESP_OKAY);
                        state_q <= S_COMPLETE;
                    end else if (timer_expired_i) begin
                        tmo_rsp_q <= 1'b1;
                        err_q     <= 1'b1;
                        state_q   <= S_DRAIN;
                    end
                end
                S_RADDR: begin
                    if (timer_expired_i) begin
                        tmo_rsp_q <= 1'b1;
                        err_q     <= 1'b1;
                        state_q   <= S_DRAIN;
                    end else if (ar_hs) begin
                        state_q <= S_RDATA;
                    end
                end
                S_RDATA: begin
                    if (r_hs) begin
                        err_q      <= (m_rresp_i != RESP_OKAY);
                        load_sel_q <= (m_rresp_i == RESP_OKAY);
                        state_q    <= S_COMPLETE;
                    end else if (timer_expired_i) begin
                        tmo_rsp_q <= 1'b1;
                        err_q     <= 1'b1;
                        state_q   <= S_DRAIN;
                    end
                end
                S_COMPLETE: begin
                    state_q <= S_IDLE;
                end
                S_DRAIN: begin
                    // late response is thrown away
                    if (b_hs || r_hs) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // request payload and read data
    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q     <= addr_i;
            wdata_q    <= wdata_i;
            wstrb_q    <= wstrb_i;
            size_q     <= size_i;
            unsigned_q <= is_unsigned_i;
            is_store_q <= is_store_i;
        end
        if ((state_q == S_RDATA) && r_hs) begin
            rdata_q <= m_rdata_i;
        end
    end

endmodule

// File: source/ls_unit.sv
`timescale 1ns/100ps

module ls_unit import lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    // request from execute
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic [ILEN-1:0]   instr_i,
    input  logic [XLEN-1:0]   addr_i,
    input  logic [XLEN-1:0]   rs2_i,
    // result to write-back
    output logic              rsp_valid_o,
    output logic [XLEN-1:0]   rsp_data_o,
    output logic              rsp_err_o,
    // AXI4-Lite master
    output logic              m_awvalid_o,
    input  logic              m_awready_i,
    output logic [XLEN-1:0]   m_awaddr_o,
    output logic              m_wvalid_o,
    input  logic              m_wready_i,
    output logic [XLEN-1:0]   m_wdata_o,
    output logic [STRB_W-1:0] m_wstrb_o,
    input  logic              m_bvalid_i,
    output logic              m_bready_o,
    input  logic [1:0]        m_bresp_i,
    output logic              m_arvalid_o,
    input  logic              m_arready_i,
    output logic [XLEN-1:0]   m_araddr_o,
    input  logic              m_rvalid_i,
    output logic              m_rready_o,
    input  logic [XLEN-1:0]   m_rdata_i,
    input  logic [1:0]        m_rresp_i
);

    // request path
    logic              is_load;
    logic              is_store;
    logic [1:0]        size;
    logic              is_unsigned;
    logic              misaligned;
    logic [XLEN-1:0]   st_wdata;
    logic [STRB_W-1:0] st_wstrb;

    // response path, registered in the FSM
    logic [XLEN-1:0]   rsp_rdata;
    logic [2:0]        rsp_lsb;
    logic [1:0]        rsp_size;
    logic              rsp_unsigned;

    logic              timer_start;
    logic              timer_clear;
    logic              timer_expired;

    ls_decode u_decode (
        .instr_i       (instr_i),
        .addr_lsb_i    (addr_i[2:0]),
        .is_load_o     (is_load),
        .is_store_o    (is_store),
        .size_o        (size),
        .is_unsigned_o (is_unsigned),
        .misaligned_o  (misaligned)
    );

    store_align u_store_align (
        .rs2_i      (rs2_i),
        .addr_lsb_i (addr_i[2:0]),
        .size_i     (size),
        .wdata_o    (st_wdata),
        .wstrb_o    (st_wstrb)
    );

    // rdata is already zero when the result is not load data
    load_align u_load_align (
        .rdata_i       (rsp_rdata),
        .addr_lsb_i    (rsp_lsb),
        .size_i        (rsp_size),
        .is_unsigned_i (rsp_unsigned),
        .load_data_o   (rsp_data_o)
    );

    bus_timer u_timer (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (timer_start),
        .clear_i   (timer_clear),
        .expired_o (timer_expired)
    );

    axil_ls_fsm u_fsm (
        .clk             (clk),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .addr_i          (addr_i),
        .is_load_i       (is_load),
        .is_store_i      (is_store),
        .misaligned_i    (misaligned),
        .size_i          (size),
        .is_unsigned_i   (is_unsigned),
        .wdata_i         (st_wdata),
        .wstrb_i         (st_wstrb),
        .timer_start_o   (timer_start),
        .timer_clear_o   (timer_clear),
        .timer_expired_i (timer_expired),
        .m_awvalid_o     (m_awvalid_o),
        .m_awready_i     (m_awready_i),
        .m_awaddr_o      (m_awaddr_o),
        .m_wvalid_o      (m_wvalid_o),
        .m_wready_i      (m_wready_i),
        .m_wdata_o       (m_wdata_o),
        .m_wstrb_o       (m_wstrb_o),
        .m_bvalid_i      (m_bvalid_i),
        .m_bready_o      (m_bready_o),
        .m_bresp_i       (m_bresp_i),
        .m_arvalid_o     (m_arvalid_o),
        .m_arready_i     (m_arready_i),
        .m_araddr_o      (m_araddr_o),
        .m_rvalid_i      (m_rvalid_i),
        .m_rready_o      (m_rready_o),
        .m_rdata_i       (m_rdata_i),
        .m_rresp_i       (m_rresp_i),
        .rdata_o         (rsp_rdata),
        .rsp_lsb_o       (rsp_lsb),
        .rsp_size_o      (rsp_size),
        .rsp_unsigned_o  (rsp_unsigned),
        .load_sel_o      (),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_err_o       (rsp_err_o)
    );

endmodule

// File: sim/axil_mem_model.sv
`timescale 1ns/100ps

module axil_mem_model import lsu_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic              clk,
    input  logic              rst_i,
    // behavior controls
    input  int                resp_delay_i,
    input  logic [XLEN-1:0]   err_addr_i,
    input  logic              hang_i,
    // AXI4-Lite slave
    input  logic              s_awvalid_i,
    output logic              s_awready_o,
    input  logic [XLEN-1:0]   s_awaddr_i,
    input  logic              s_wvalid_i,
    output logic              s_wready_o,
    input  logic [XLEN-1:0]   s_wdata_i,
    input  logic [STRB_W-1:0] s_wstrb_i,
    output logic              s_bvalid_o,
    input  logic              s_bready_i,
    output logic [1:0]        s_bresp_o,
    input  logic              s_arvalid_i,
    output logic              s_arready_o,
    input  logic [XLEN-1:0]   s_araddr_i,
    output logic              s_rvalid_o,
    input  logic              s_rready_i,
    output logic [XLEN-1:0]   s_rdata_o,
    output logic [1:0]        s_rresp_o
);

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [XLEN-1:0]   mem [DEPTH];
    logic [XLEN-1:0]   ar_q;
    logic [XLEN-1:0]   aw_q;
    logic [XLEN-1:0]   wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic              r_busy;
    logic              aw_got;
    logic              w_got;
    int                r_cnt;
    int                w_cnt;

    assign s_arready_o = ~r_busy;
    assign s_awready_o = ~aw_got;
    assign s_wready_o  = ~w_got;

    // read side, one transaction at a time
    always @(posedge clk) begin
        if (rst_i) begin
            r_busy     <= 1'b0;
            s_rvalid_o <= 1'b0;
            s_rresp_o  <= RESP_OKAY;
            s_rdata_o  <= '0;
            r_cnt      <= 0;
        end else if (s_rvalid_o) begin
            if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
                r_busy     <= 1'b0;
            end
        end else if (r_busy) begin
            // hang holds the response back indefinitely
            if (!hang_i && r_cnt >= resp_delay_i) begin
                s_rvalid_o <= 1'b1;
                if (ar_q == err_addr_i) begin
                    s_rresp_o <= RESP_SLVERR;
                    // junk data that the master must discard
                    s_rdata_o <= '1;
                end else begin
                    s_rresp_o <= RESP_OKAY;
                    s_rdata_o <= mem[ar_q[8:3]];
                end
            end else begin
                r_cnt <= r_cnt + 1;
            end
        end else if (s_arvalid_i) begin
            ar_q   <= s_araddr_i;
            r_busy <= 1'b1;
            r_cnt  <= 0;
        end
    end

    // write side, address and data may arrive in either order
    always @(posedge clk) begin
        if (rst_i) begin
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            s_bvalid_o <= 1'b0;
            s_bresp_o  <= RESP_OKAY;
            w_cnt      <= 0;
        end else if (s_bvalid_o) begin
            if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
                aw_got     <= 1'b0;
                w_got      <= 1'b0;
            end
        end else if (aw_got && w_got) begin
            if (!hang_i && w_cnt >= resp_delay_i) begin
                s_bvalid_o <= 1'b1;
                if (aw_q == err_addr_i) begin
                    s_bresp_o <= RESP_SLVERR;
                end else begin
                    s_bresp_o <= RESP_OKAY;
                    for (int i = 0; i < STRB_W; i++) begin
                        if (wstrb_q[i]) begin
                            mem[aw_q[8:3]][8*i +: 8] <= wdata_q[8*i +: 8];
                        end
                    end
                end
            end else begin
                w_cnt <= w_cnt + 1;
            end
        end else begin
            w_cnt <= 0;
            if (s_awvalid_i && !aw_got) begin
                aw_q   <= s_awaddr_i;
                aw_got <= 1'b1;
            end
            if (s_wvalid_i && !w_got) begin
                wdata_q <= s_wdata_i;
                wstrb_q <= s_wstrb_i;
                w_got   <= 1'b1;
            end
        end
    end

endmodule

// File: sim/tb_ls_unit.sv
`timescale 1ns/100ps

module tb_ls_unit import lsu_pkg::*; ();

    localparam logic [63:0] BASE    = 64'h100;
    localparam logic [63:0] NO_ERR  = 64'hFFFF_FFFF_FFFF_FFF8;
    localparam int          NWORDS  = 4;
    // roughly 130 requests of up to ten cycles plus the hang wait, with margin
    localparam int          CYCLE_LIMIT = 2000;
    localparam logic [6:0]  OP_LOAD  = 7'b0000011;
    localparam logic [6:0]  OP_STORE = 7'b0100011;
    localparam logic [6:0]  OP_IMM   = 7'b0010011;

    logic              clk;
    logic              rst_i;
    logic              req_valid;
    logic              req_ready;
    logic [ILEN-1:0]   instr;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   rs2;
    logic              rsp_valid;
    logic [XLEN-1:0]   rsp_data;
    logic              rsp_err;
    logic              m_awvalid;
    logic              m_awready;
    logic [XLEN-1:0]   m_awaddr;
    logic              m_wvalid;
    logic              m_wready;
    logic [XLEN-1:0]   m_wdata;
    logic [STRB_W-1:0] m_wstrb;
    logic              m_bvalid;
    logic              m_bready;
    logic [1:0]        m_bresp;
    logic              m_arvalid;
    logic              m_arready;
    logic [XLEN-1:0]   m_araddr;
    logic              m_rvalid;
    logic              m_rready;
    logic [XLEN-1:0]   m_rdata;
    logic [1:0]        m_rresp;
    int                resp_delay;
    logic [XLEN-1:0]   err_addr;
    logic              hang;

    logic [7:0] ref_mem [512];
    integer     seed = 32'h9274_1008;
    int         cycle_count = 0;

    ls_unit uut (
        .clk (clk), .rst_i (rst_i),
        .req_valid_i (req_valid), .req_ready_o (req_ready), .instr_i (instr),
        .addr_i (addr), .rs2_i (rs2),
        .rsp_valid_o (rsp_valid), .rsp_data_o (rsp_data), .rsp_err_o (rsp_err),
        .m_awvalid_o (m_awvalid), .m_awready_i (m_awready), .m_awaddr_o (m_awaddr),
        .m_wvalid_o (m_wvalid), .m_wready_i (m_wready), .m_wdata_o (m_wdata),
        .m_wstrb_o (m_wstrb), .m_bvalid_i (m_bvalid), .m_bready_o (m_bready),
        .m_bresp_i (m_bresp), .m_arvalid_o (m_arvalid), .m_arready_i (m_arready),
        .m_araddr_o (m_araddr), .m_rvalid_i (m_rvalid), .m_rready_o (m_rready),
        .m_rdata_i (m_rdata), .m_rresp_i (m_rresp)
    );

    axil_mem_model mem_model (
        .clk (clk), .rst_i (rst_i),
        .resp_delay_i (resp_delay), .err_addr_i (err_addr), .hang_i (hang),
        .s_awvalid_i (m_awvalid), .s_awready_o (m_awready), .s_awaddr_i (m_awaddr),
        .s_wvalid_i (m_wvalid), .s_wready_o (m_wready), .s_wdata_i (m_wdata),
        .s_wstrb_i (m_wstrb), .s_bvalid_o (m_bvalid), .s_bready_i (m_bready),
        .s_bresp_o (m_bresp), .s_arvalid_i (m_arvalid), .s_arready_o (m_arready),
        .s_araddr_i (m_araddr), .s_rvalid_o (m_rvalid), .s_rready_i (m_rready),
        .s_rdata_o (m_rdata), .s_rresp_o (m_rresp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ends a stuck run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped at %0t: no progress within %0d cycles", $time, CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // a raised AXI address must be the double-word holding the request
    task automatic check_bus_addr(input logic [63:0] a);
        if (m_arvalid) begin
            check_val("m_araddr_o", a & ~64'h7, m_araddr);
        end
        if (m_awvalid) begin
            check_val("m_awaddr_o", a & ~64'h7, m_awaddr);
        end
    endtask

    function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic [2:0] f3);
        return {17'd0, f3, 5'd0, opc};
    endfunction

    // little-endian read of the reference bytes, then sign or zero fill
    function automatic logic [63:0] expect_load(input logic [63:0] a, input logic [2:0] f3);
        int          n;
        logic [63:0] v;
        n = 1 << f3[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[a[8:0] + i];
        end
        if (!f3[2] && n < 8 && v[8*n-1]) begin
            v = v | (~64'd0 << (8 * n));
        end
        return v;
    endfunction

    task automatic issue(input logic [31:0] ins, input logic [63:0] a, input logic [63:0] d,
                         output logic [63:0] data, output logic err, output int lat,
                         output logic bus_used);
        @(negedge clk);
        req_valid = 1'b1;
        instr     = ins;
        addr      = a;
        rs2       = d;
        while (!req_ready) begin
            @(negedge clk);
        end
        // accepted on the posedge just passed
        @(negedge clk);
        req_valid = 1'b0;
        lat       = 1;
        bus_used  = m_arvalid | m_awvalid | m_wvalid;
        check_bus_addr(a);
        while (!rsp_valid) begin
            @(negedge clk);
            lat++;
            bus_used = bus_used | m_arvalid | m_awvalid | m_wvalid;
            check_bus_addr(a);
        end
        data = rsp_data;
        err  = rsp_err;
    endtask

    task automatic run_store(input logic [63:0] a, input logic [2:0] f3, input logic [63:0] d);
        logic [63:0] data;
        logic        err;
        int          lat;
        logic        bus_used;
        issue(make_instr(OP_STORE, f3), a, d, data, err, lat, bus_used);
        check_val("rsp_err_o", 0, err);
        check_val("rsp_data_o", 0, data);
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            ref_mem[a[8:0] + i] = d[8*i +: 8];
        end
    endtask

    task automatic run_load(input logic [63:0] a, input logic [2:0] f3);
        logic [63:0] data;
        logic        err;
        int          lat;
        logic        bus_used;
        issue(make_instr(OP_LOAD, f3), a, 64'd0, data, err, lat, bus_used);
        check_val("rsp_err_o", 0, err);
        check_val("rsp_data_o", expect_load(a, f3), data);
    endtask

    task automatic reset_state_test();
        check_val("req_ready_o", 1, req_ready);
        check_val("rsp_valid_o", 0, rsp_valid);
        check_val("m_arvalid_o", 0, m_arvalid);
        check_val("m_awvalid_o", 0, m_awvalid);
        check_val("m_wvalid_o", 0, m_wvalid);
        check_val("m_bready_o", 0, m_bready);
        check_val("m_rready_o", 0, m_rready);
    endtask

    task automatic fill_memory();
        for (int w = 0; w < NWORDS; w++) begin
            run_store(BASE + 8 * w, 3'd3, {$random(seed), $random(seed)});
        end
    endtask

    task automatic store_sizes_test();
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                run_store(BASE + off, s[2:0], {$random(seed), $random(seed)});
                run_load(BASE, 3'd3);
            end
        end
    endtask

    task automatic load_offsets_test(input int delay);
        @(negedge clk);
        resp_delay = delay;
        fill_memory();
        // funct3 0 to 6 cover lb lh lw ld lbu lhu lwu
        for (int f = 0; f < 7; f++) begin
            for (int off = 0; off < 8; off += (1 << f[1:0])) begin
                run_load(BASE + 8 + off, f[2:0]);
            end
        end
        @(negedge clk);
        resp_delay = 0;
    endtask

    task automatic single_cycle_case(input logic [31:0] ins, input logic [63:0] a,
                                     input logic exp_err);
        logic [63:0] data;
        logic        err;
        int          lat;
        logic        bus_used;
        issue(ins, a, 64'hDEAD_BEEF_0BAD_F00D, data, err, lat, bus_used);
        check_val("rsp_valid_o latency", 1, lat);
        check_val("rsp_err_o", exp_err, err);
        check_val("rsp_data_o", 0, data);
        check_val("axi valid", 0, bus_used);
    endtask

    task automatic misaligned_test();
        single_cycle_case(make_instr(OP_LOAD, 3'd1), BASE + 1, 1'b1);
        single_cycle_case(make_instr(OP_LOAD, 3'd2), BASE + 2, 1'b1);
        single_cycle_case(make_instr(OP_STORE, 3'd3), BASE + 4, 1'b1);
        single_cycle_case(make_instr(OP_IMM, 3'd0), BASE, 1'b0);
        // the rejected sd must not have touched memory
        run_load(BASE, 3'd3);
    endtask

    task automatic bus_error_test();
        logic [63:0] data;
        logic        err;
        int          lat;
        logic        bus_used;
        @(negedge clk);
        err_addr = BASE + 16;
        issue(make_instr(OP_LOAD, 3'd3), BASE + 16, 64'd0, data, err, lat, bus_used);
        check_val("rsp_err_o", 1, err);
        check_val("rsp_data_o", 0, data);
        issue(make_instr(OP_STORE, 3'd0), BASE + 19, 64'h5A, data, err, lat, bus_used);
        check_val("rsp_err_o", 1, err);
        check_val("rsp_data_o", 0, data);
        @(negedge clk);
        err_addr = NO_ERR;
        run_load(BASE + 16, 3'd3);
    endtask

    task automatic hang_test();
        logic [63:0] data;
        logic        err;
        int          lat;
        logic        bus_used;
        @(negedge clk);
        hang = 1'b1;
        issue(make_instr(OP_LOAD, 3'd3), BASE + 24, 64'd0, data, err, lat, bus_used);
        check_val("rsp_err_o", 1, err);
        check_val("rsp_data_o", 0, data);
        if (lat < BUS_TIMEOUT) begin
            $display("[FAIL] time %0t: timeout response came after only %0d cycles", $time, lat);
            $display("Simulation failed");
            $fatal(1, "early timeout");
        end
        @(negedge clk);
        hang = 1'b0;
        // unit drains the late read before taking this one
        // another double-word, so the late data cannot pass for it
        run_load(BASE + 8, 3'd3);
    endtask

    initial begin
        rst_i      = 1'b1;
        req_valid  = 1'b0;
        instr      = '0;
        addr       = '0;
        rs2        = '0;
        resp_delay = 0;
        err_addr   = NO_ERR;
        hang       = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        reset_state_test();
        fill_memory();
        store_sizes_test();
        load_offsets_test(0);
        load_offsets_test(3);
        misaligned_test();
        bus_error_test();
        hang_test();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: filelist.f
source/lsu_pkg.sv
source/ls_decode.sv
source/store_align.sv
source/load_align.sv
source/bus_timer.sv
source/axil_ls_fsm.sv
source/ls_unit.sv
sim/axil_mem_model.sv
sim/tb_ls_unit.sv
